//--- mcp_pkg.sv
// mcp control chip shared definitions
// microword, decode strobes, phase ring and bus strobe types,
// opcodes and the address constants of the sequencer
package mcp_pkg;

   localparam int ADDR_W = 11;                            // location counter width
   localparam logic [ADDR_W-1:0] RESET_ADDR = 11'd1;      // first fetch after reset
   localparam logic [2:0] TRANS_PFX = 3'b100;             // opcode translation page
   localparam logic [7:0] IRQ_PFX = 8'h02;                // interrupt vector page

   typedef enum logic [3:0]
   {
      op_nop    = 4'h0,                                   // fall through
      op_jmp    = 4'h1,                                   // jump to arg
      op_jcond  = 4'h2,                                   // jump if jc
      op_call   = 4'h3,                                   // save inc, jump
      op_ret    = 4'h4,                                   // back to rr
      op_ldtr   = 4'h5,                                   // tr from data in
      op_trans  = 4'h6,                                   // jump to pta
      op_rd     = 4'h7,                                   // bus read
      op_wr     = 4'h8,                                   // bus write
      op_wrb    = 4'h9,                                   // bus write byte
      op_iak    = 4'ha,                                   // interrupt ack
      op_irqset = 4'hb,                                   // set flags 7..5
      op_irqclr = 4'hc                                    // clear flags 7..5
   } mcp_op_e;

   typedef struct packed
   {
      mcp_op_e     op;                                    // opcode
      logic [11:0] arg;                                   // low bits are target
   } mi_t;

   typedef struct packed
   {
      logic jump;                                         // unconditional jump
      logic cond;                                         // conditional jump
      logic call;                                         // subroutine call
      logic ret;                                          // return
      logic trans;                                        // translation jump
      logic ldtr;                                         // load tr
      logic rd;                                           // read cycle
      logic wr;                                           // write cycle
      logic wrbyte;                                       // byte qualifier
      logic iak;                                          // ack cycle
      logic set;                                          // irq flag set
      logic clr;                                          // irq flag clear
      logic bus;                                          // any bus op
   } dec_t;

   typedef struct packed
   {
      logic c1;
      logic c2;
      logic c3;
      logic c4;
   } phase_t;

   typedef struct packed
   {
      logic syn;                                          // cycle sync
      logic din;                                          // data in
      logic dout;                                         // data out
      logic wtbt;                                         // write byte
      logic iako;                                         // interrupt ack out
   } bus_ctl_t;

endpackage

//--- mcp_phase.sv
// mcp microcycle phase generator
// one-hot ring c1..c4 derived from clk, the chip's own four-phase clock;
// holds in c3 while the bus block asks for wait states
`timescale 1ns/10ps

module mcp_phase
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             stall,       // wait request from bus block
   output mcp_pkg::phase_t  phase
);

always_ff @(posedge clk or negedge rst_n)
begin
   if (!rst_n)
      phase <= '{c1: 1'b1, default: 1'b0};               // start of microcycle
   else
      if (!(phase.c3 && stall))                          // c3 stretched by wait
         phase <= '{c1: phase.c4,
                    c2: phase.c1,
                    c3: phase.c2,
                    c4: phase.c3};                        // rotate ring
end

endmodule

//--- mcp_plc.sv
// mcp microinstruction decoder
// turns the opcode of the microinstruction register into the
// decode strobe set, latched so it is valid from c3 to next c2
`timescale 1ns/10ps

module mcp_plc
(
   input  logic             clk,
   input  logic             rst_n,
   input  mcp_pkg::phase_t  phase,
   input  mcp_pkg::mi_t     mir,         // latched microword
   output mcp_pkg::dec_t    dec          // decode strobes from c3
);
   import mcp_pkg::*;

   dec_t dec_d;                                           // raw decoder output

always_comb
begin
   dec_d = '0;
   case (mir.op)
      op_jmp:    dec_d.jump  = 1'b1;
      op_jcond:  dec_d.cond  = 1'b1;
      op_call:   dec_d.call  = 1'b1;
      op_ret:    dec_d.ret   = 1'b1;
      op_ldtr:   dec_d.ldtr  = 1'b1;
      op_trans:  dec_d.trans = 1'b1;
      op_rd:     dec_d.rd    = 1'b1;
      op_wr:     dec_d.wr    = 1'b1;
      op_wrb:
      begin
         dec_d.wr     = 1'b1;                             // byte write is a write
         dec_d.wrbyte = 1'b1;                             // plus the byte qualifier
      end
      op_iak:    dec_d.iak   = 1'b1;
      op_irqset: dec_d.set   = 1'b1;
      op_irqclr: dec_d.clr   = 1'b1;
      default:   dec_d       = '0;                        // nop and unused codes
   endcase
   dec_d.bus = dec_d.rd | dec_d.wr | dec_d.iak;           // one line for the bus block
end

always_ff @(posedge clk or negedge rst_n)
begin
   if (!rst_n)
      dec <= '0;
   else
      if (phase.c2)                                       // mir settled since c2
         dec <= dec_d;                                    // visible from c3
end

endmodule

//--- mcp_pta.sv
// mcp translation array
// priority encodes the seven interrupt requests into a vector address;
// with nothing pending, forms the opcode translation address from tr
`timescale 1ns/10ps

module mcp_pta
(
   input  logic [15:0]                tr,        // translation register
   input  logic [7:1]                 irq,       // 4..1 external, 7..5 internal
   output logic [mcp_pkg::ADDR_W-1:0] pta,       // translation address
   output logic                       irq_hit    // any request pending
);
   import mcp_pkg::*;

   logic [2:0]        irq_num;                            // winning request
   logic [ADDR_W-1:0] vec_addr;                           // interrupt vector
   logic [ADDR_W-1:0] op_addr;                            // opcode entry

always_comb
begin
   irq_num = 3'd0;
   for (int i = 1; i <= 7; i++)                           // later wins, so 7 is top
      if (irq[i])
         irq_num = i[2:0];
end

assign irq_hit  = |irq;
assign vec_addr = {IRQ_PFX, irq_num};
assign op_addr  = {TRANS_PFX, tr[15:12], 4'b0000};        // 16 words per group

assign pta = irq_hit ? vec_addr : op_addr;                // interrupts first

endmodule

//--- mcp_seq.sv
// mcp microprogram sequencer
// location counter, increment, return and translation registers,
// microinstruction register and interrupt flags; picks the next
// address in c3, loads it into lc at the end of c4
`timescale 1ns/10ps

module mcp_seq
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  mcp_pkg::phase_t            phase,
   input  mcp_pkg::dec_t              dec,
   input  mcp_pkg::mi_t               mword,     // from external store
   input  logic                       jc,        // jump condition
   input  logic [3:0]                 irq_ext,   // external requests
   input  logic [15:0]                din_data,  // bus data for ldtr
   output logic [mcp_pkg::ADDR_W-1:0] maddr,     // store address
   output mcp_pkg::mi_t               mir
);
   import mcp_pkg::*;

   logic [ADDR_W-1:0] lc;                                 // location counter
   logic [ADDR_W-1:0] inc;                                // lc plus one
   logic [ADDR_W-1:0] rr;                                 // return register
   logic [ADDR_W-1:0] nxt;                                // chosen next address
   logic [ADDR_W-1:0] nxt_d;
   logic              vec;                                // vector entry taken
   logic [15:0]       tr;                                 // translation register
   logic [7:1]        irq;                                // request flags
   logic [ADDR_W-1:0] pta;
   logic              irq_hit;

mcp_pta pta_arr
(
   .tr(tr),
   .irq(irq),
   .pta(pta),
   .irq_hit(irq_hit)
);

assign maddr = lc;                                        // held c1 through c4

// next address priority: translation/vector, return, jumps, increment
always_comb
begin
   nxt_d = inc;
   if (dec.trans)
      nxt_d = pta;                                        // vector when irq_hit
   else if (dec.ret)
      nxt_d = rr;
   else if (dec.call || dec.jump || (dec.cond && jc))
      nxt_d = mir.arg[ADDR_W-1:0];
end

always_ff @(posedge clk or negedge rst_n)
begin
   if (!rst_n)
   begin
      lc  <= RESET_ADDR;
      inc <= '0;
      rr  <= '0;
      nxt <= RESET_ADDR;
      vec <= 1'b0;
      tr  <= '0;
      irq <= '0;
      mir <= '{op: op_nop, arg: '0};
   end
   else
   begin
      if (phase.c1)
         mir <= mword;                                    // store answers during c1
      if (phase.c2)
         inc <= lc + 1'b1;
      if (phase.c2 && (mir.op == op_ldtr))
         tr <= din_data;                                  // ready by c3
      if (phase.c3)                                       // repeats while stretched
      begin
         nxt      <= nxt_d;                               // jc sampled here
         vec      <= dec.trans & irq_hit;
         irq[4:1] <= irq_ext;
      end
      if (phase.c4)
      begin
         lc <= nxt;                                       // new address in c1
         if (dec.call || vec)
            rr <= inc;                                    // vector entry keeps return point
         if (dec.set)
            irq[7:5] <= irq[7:5] | mir.arg[2:0];
         else if (dec.clr)
            irq[7:5] <= irq[7:5] & ~mir.arg[2:0];
      end
   end
end

endmodule

//--- mcp_qbus.sv
// mcp bus control
// strobe latches for sync, data in, data out, write byte and
// interrupt ack, plus the wait that stretches c3 until ready
`timescale 1ns/10ps

module mcp_qbus
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ra,          // bus ready
   input  mcp_pkg::phase_t   phase,
   input  mcp_pkg::dec_t     dec,
   output mcp_pkg::bus_ctl_t bus,
   output logic              stall        // hold phase in c3
);
   import mcp_pkg::*;

   bus_ctl_t strb;                                        // strobes for this op
   logic     rise;                                        // last c3 clk, ready seen
   logic     fall;                                        // end of microcycle

// wait only matters for a bus op, and only in c3
assign stall = phase.c3 & dec.bus & ~ra;

always_comb
begin
   strb.syn  = dec.bus;
   strb.din  = dec.rd;
   strb.dout = dec.wr;                                    // wr and wrb
   strb.wtbt = dec.wrbyte;                                // only with dout
   strb.iako = dec.iak;
end

assign rise = phase.c3 & ~stall;
assign fall = phase.c4;

always_ff @(posedge clk or negedge rst_n)
begin
   if (!rst_n)
      bus <= '0;
   else
   begin
      if (rise)
         bus <= strb;                                     // high during c4
      else if (fall)
         bus <= '0;                                       // low again from c1
   end
end

endmodule

//--- mcp_top.sv
// mcp control chip top level
// phase ring, sequencer, decoder and bus control of the microprogram
// control chip; store address and microword on separate ports
`timescale 1ns/10ps

module mcp_top
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       ra,        // bus ready
   input  logic                       jc,        // jump condition
   input  logic [3:0]                 irq_ext,   // external requests
   input  logic [15:0]                din_data,  // data for ldtr
   input  mcp_pkg::mi_t               mword,     // microword from store
   output logic [mcp_pkg::ADDR_W-1:0] maddr,     // microcode address
   output mcp_pkg::bus_ctl_t          bus        // bus strobes
);
   import mcp_pkg::*;

   phase_t phase;                                         // c1..c4 one-hot
   logic   stall;                                         // wait from bus block
   dec_t   dec;                                           // latched decode
   mi_t    mir;                                           // microinstruction reg

mcp_phase phs
(
   .clk(clk),
   .rst_n(rst_n),
   .stall(stall),
   .phase(phase)
);

mcp_seq seq
(
   .clk(clk),
   .rst_n(rst_n),
   .phase(phase),
   .dec(dec),
   .mword(mword),
   .jc(jc),
   .irq_ext(irq_ext),
   .din_data(din_data),
   .maddr(maddr),
   .mir(mir)
);

mcp_plc plc
(
   .clk(clk),
   .rst_n(rst_n),
   .phase(phase),
   .mir(mir),
   .dec(dec)
);

mcp_qbus qbus
(
   .clk(clk),
   .rst_n(rst_n),
   .ra(ra),
   .phase(phase),
   .dec(dec),
   .bus(bus),
   .stall(stall)
);

endmodule

//--- mcp_asserts.sv
// mcp control chip assertions
// phase ring, bus strobe and store address rules, bound to the top level
`timescale 1ns/10ps

module mcp_asserts
(
   input logic                       clk,
   input logic                       rst_n,
   input mcp_pkg::phase_t            phase,
   input logic [mcp_pkg::ADDR_W-1:0] maddr,
   input mcp_pkg::bus_ctl_t          bus
);

phase_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(phase))
   else $error("phase ring is not one-hot");

syn_dir: assert property (@(posedge clk) disable iff (!rst_n)
   bus.syn |-> !(bus.din && bus.dout))
   else $error("sync with both data in and data out");

// lc only moves at the end of c4, so every sample outside c1 sees the old value
maddr_hold: assert property (@(posedge clk) disable iff (!rst_n)
   !phase.c1 |-> $stable(maddr))
   else $error("store address moved inside a microcycle");

bus_reset: assert property (@(negedge clk) !rst_n |-> (bus == '0))
   else $error("bus strobes active in reset");             // mid-cycle, after reset edge

endmodule

bind mcp_top mcp_asserts chk
(
   .clk(clk),
   .rst_n(rst_n),
   .phase(phase),
   .maddr(maddr),
   .bus(bus)
);

//--- tb_clk.sv
// testbench clock and reset for the mcp control chip
// 100 ns clock, rst_n held low for the first 4 cycles
`timescale 1ns/10ps

module tb_clk
(
   output logic clk,
   output logic rst_n
);

initial
begin
   clk   = 1'b0;
   rst_n = 1'b0;                                          // in reset from time 0
   repeat (4) @(posedge clk);
   #10 rst_n = 1'b1;                                      // release off the edge
end

always #50 clk = ~clk;                                    // 100 ns period

endmodule

//--- tb_mcp_top.sv
// testbench for the mcp control chip
// models the external microcode store, runs directed microprograms
// and checks next address, microcycle length and bus strobes
`timescale 1ns/10ps

module tb_mcp_top;
   import mcp_pkg::*;

   localparam int N_UC    = 28;                           // microcycles over all tests
   localparam int WDOG_NS = (N_UC * 12 * 100 * 3) / 2 + 400; // 1.5x at 12 clk plus reset

   logic              clk;
   logic              rst_n;
   logic              ra;
   logic              jc;
   logic [3:0]        irq_ext;
   logic [15:0]       din_data;
   mi_t               mword;
   logic [ADDR_W-1:0] maddr;
   bus_ctl_t          bus;
   mi_t               store [0:2**ADDR_W-1];             // microcode store model
   logic [ADDR_W-1:0] pc;                                 // address of current microcycle
   integer            seed = 87537;

tb_clk clkgen
(
   .clk(clk),
   .rst_n(rst_n)
);

mcp_top UUT
(
   .clk(clk),
   .rst_n(rst_n),
   .ra(ra),
   .jc(jc),
   .irq_ext(irq_ext),
   .din_data(din_data),
   .mword(mword),
   .maddr(maddr),
   .bus(bus)
);

assign mword = store[maddr];                              // store answers at once

task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
   begin
      if (got !== exp)
      begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "mismatch on %s", name);
      end
   end
endtask

task automatic load_word(input logic [ADDR_W-1:0] a, input mcp_op_e op, input logic [11:0] arg);
   store[a] = '{op: op, arg: arg};
endtask

// strobes expected in c4 of a bus op
function automatic bus_ctl_t strobes(input mcp_op_e op);
   bus_ctl_t s;
   s      = '0;
   s.syn  = 1'b1;
   s.din  = (op == op_rd);
   s.dout = (op == op_wr) || (op == op_wrb);
   s.wtbt = (op == op_wrb);                               // byte write only
   s.iako = (op == op_iak);
   return s;
endfunction

// one microcycle at pc, ra low for d clks of c3, then expect nxt
task automatic run_uc(input logic [ADDR_W-1:0] nxt, input int d, input bus_ctl_t eb);
   int n;
   begin
      n = 0;
      check("maddr", maddr, pc);
      do
      begin
         ra = !(n >= 2 && n < 2 + d);                     // c3 is clk index 2 on
         check("bus", bus, (n == 3 + d) ? eb : bus_ctl_t'(0));
         @(posedge clk);
         #10;
         n++;
      end
      while (maddr == pc && n < 4 + d);                   // maddr moves at c1
      check("microcycle length", n, 4 + d);
      check("maddr", maddr, nxt);
      check("bus", bus, 5'b0);                            // strobes low again in c1
      pc = nxt;
   end
endtask

task automatic test_nop_run;
   for (int i = 0; i < 6; i++)
      run_uc(pc + 1'b1, 0, '0);                           // default fill is nop
endtask

task automatic test_jump_call;
   begin
      load_word(pc, op_jmp, 12'h100);
      run_uc(11'h100, 0, '0);
      load_word(pc, op_call, 12'h200);
      run_uc(11'h200, 0, '0);
      load_word(pc, op_nop, 12'h0);
      run_uc(11'h201, 0, '0);
      load_word(pc, op_ret, 12'h0);
      run_uc(11'h101, 0, '0);                             // back after the call
   end
endtask

task automatic test_jcond;
   begin
      jc = 1'b1;
      load_word(pc, op_jcond, 12'h300);
      run_uc(11'h300, 0, '0);
      jc = 1'b0;
      load_word(pc, op_jcond, 12'h380);
      run_uc(pc + 1'b1, 0, '0);                           // not taken
   end
endtask

task automatic test_bus_cycles;
   mcp_op_e ops [4];
   int      d;
   begin
      ops = '{op_rd, op_wr, op_wrb, op_iak};
      for (int r = 0; r < 2; r++)
         for (int i = 0; i < 4; i++)
         begin
            d = $unsigned($random(seed)) % 4;             // wait states
            load_word(pc, ops[i], 12'h0);
            run_uc(pc + 1'b1, d, strobes(ops[i]));
         end
   end
endtask

task automatic test_translation;
   logic [ADDR_W-1:0] t_addr;
   begin
      din_data = 16'($random(seed));
      t_addr   = {TRANS_PFX, din_data[15:12], 4'b0000};
      load_word(pc, op_ldtr, 12'h0);
      run_uc(pc + 1'b1, 0, '0);
      load_word(pc, op_trans, 12'h0);
      run_uc(t_addr, 0, '0);                              // no requests yet
      irq_ext = 4'b0101;                                  // requests 1 and 3
      run_uc(pc + 1'b1, 0, '0);
      load_word(pc, op_trans, 12'h0);
      run_uc({IRQ_PFX, 3'd3}, 0, '0);
      load_word(pc, op_irqset, 12'h002);                  // flag 6
      run_uc(pc + 1'b1, 0, '0);
      load_word(pc, op_trans, 12'h0);
      run_uc({IRQ_PFX, 3'd6}, 0, '0);                     // internal beats external
      irq_ext = 4'b0000;
      load_word(pc, op_irqclr, 12'h002);
      run_uc(pc + 1'b1, 0, '0);
      load_word(pc, op_trans, 12'h0);
      run_uc(t_addr, 0, '0);                              // back to opcode entry
   end
endtask

initial
begin
   ra       = 1'b1;
   jc       = 1'b0;
   irq_ext  = '0;
   din_data = '0;
   for (int a = 0; a < 2**ADDR_W; a++)
      store[a] = '{op: op_nop, arg: 12'(a)};              // nop with arg tagging the address
   pc = RESET_ADDR;
   @(posedge rst_n);                                      // 10 ns into first c1
   test_nop_run();
   test_jump_call();
   test_jcond();
   test_bus_cycles();
   test_translation();
   $display("Simulation passed");
   $finish;
end

initial
begin
   #(WDOG_NS);
   $display("timeout: the microprograms did not finish in the expected time");
   $display("Simulation failed");
   $fatal(1, "watchdog expired");
end

endmodule

//--- mcp_top.f
mcp_pkg.sv
mcp_phase.sv
mcp_plc.sv
mcp_pta.sv
mcp_seq.sv
mcp_qbus.sv
mcp_top.sv
mcp_asserts.sv
tb_clk.sv
tb_mcp_top.sv

//--- Makefile
SRCS = $(shell cat mcp_top.f)

all: run

obj_dir/Vtb_mcp_top: mcp_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mcp_top -f mcp_top.f

run: obj_dir/Vtb_mcp_top
	@out=$$(./obj_dir/Vtb_mcp_top); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean
